// ==== Bender.yml ====
package:
  name: i2s_rx_dma

sources:
  - files:
      - i2s_rx_pkg.sv
      - i2s_rx_deser.sv
      - i2s_rx_fifo.sv
      - i2s_rx_regs.sv
      - i2s_rx_dma_ctrl.sv
      - i2s_rx_dma.sv
  - target: test
    files:
      - i2s_rx_dma_sva.sv
      - tb_i2s_rx_dma.sv

// ==== i2s_rx_deser.sv ====
// I2S line synchronizers, serial clock edge detect, left word shifter and clock stop detector
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_deser #(
	parameter int STOP_TIMEOUT = 64
) (
	input  wire                  wbs_clk_i,
	input  wire                  rst_i,
	input  wire                  i2s_sck_i,
	input  wire                  i2s_ws_i,
	input  wire                  i2s_sd_i,
	input  wire                  en_i,
	output i2s_rx_pkg::sample_t  sample_o,
	output logic                 sample_push_o,
	output logic                 stopped_o
);

	localparam int SW     = i2s_rx_pkg::SAMPLE_W;
	localparam int CNT_W  = $clog2(SW);
	localparam int STOP_W = $clog2(STOP_TIMEOUT + 1);

	// --------------------------------------------------
	// Two flop synchronizers, one set per line
	// --------------------------------------------------
	logic [2:0] sync1_q;
	logic [2:0] sync2_q;
	logic       sck_d_q;
	logic       ws_last_q;
	logic       sck_rise;
	logic       sck_edge;
	logic       ws_fall;

	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			sck_d_q <= 1'b0;
		end else begin
			sync1_q <= {i2s_sck_i, i2s_ws_i, i2s_sd_i};
			sync2_q <= sync1_q;
			sck_d_q <= sync2_q[2];
		end
	end

	assign sck_rise = sync2_q[2] & ~sck_d_q;
	assign sck_edge = sync2_q[2] ^ sck_d_q;

	// WS seen low after being high at the previous rising edge
	assign ws_fall  = ws_last_q & ~sync2_q[1];

	// --------------------------------------------------
	// Left word shifter
	// --------------------------------------------------
	logic             active_q;
	logic [CNT_W-1:0] bit_cnt_q;
	logic [SW-1:0]    shift_q;

	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			ws_last_q     <= 1'b0;
			active_q      <= 1'b0;
			bit_cnt_q     <= '0;
			sample_push_o <= 1'b0;
		end else begin
			sample_push_o <= 1'b0;
			if (sck_rise) begin
				ws_last_q <= sync2_q[1];
				if (ws_fall) begin
					// First bit after the WS change belongs to the right word
					active_q  <= 1'b1;
					bit_cnt_q <= '0;
				end else if (active_q) begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (bit_cnt_q == CNT_W'(SW - 1)) begin
						active_q      <= 1'b0;
						sample_push_o <= en_i;
					end
				end
			end
		end
	end

	// Payload only, MSB first
	always_ff @(posedge wbs_clk_i) begin
		if (sck_rise && active_q && !ws_fall)
			shift_q <= {shift_q[SW-2:0], sync2_q[0]};
	end

	assign sample_o = shift_q;

	// --------------------------------------------------
	// Stopped clock detect
	// --------------------------------------------------
	logic [STOP_W-1:0] stop_cnt_q;

	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || !en_i || sck_edge) begin
			stop_cnt_q <= '0;
			stopped_o  <= 1'b0;
		end else if (stop_cnt_q == STOP_W'(STOP_TIMEOUT)) begin
			stopped_o <= 1'b1;
		end else begin
			stop_cnt_q <= stop_cnt_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== i2s_rx_dma.f ====
i2s_rx_pkg.sv
i2s_rx_deser.sv
i2s_rx_fifo.sv
i2s_rx_regs.sv
i2s_rx_dma_ctrl.sv
i2s_rx_dma.sv
i2s_rx_dma_sva.sv
tb_i2s_rx_dma.sv

// ==== i2s_rx_dma.sv ====
// Top level of the I2S receiver, wires deserializer, FIFO, registers and DMA controller
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_dma #(
	parameter int FIFO_DEPTH   = 16,
	parameter int STOP_TIMEOUT = 64
) (
	input  wire                   wbs_clk_i,
	input  wire                   rst_i,
	input  wire                   wbs_cyc_i,
	input  wire                   wbs_stb_i,
	input  wire                   wbs_we_i,
	input  i2s_rx_pkg::wb_addr_t  wbs_adr_i,
	input  i2s_rx_pkg::wb_data_t  wbs_dat_i,
	output i2s_rx_pkg::wb_data_t  wbs_dat_o,
	output logic                  wbs_ack_o,
	input  wire                   i2s_sck_i,
	input  wire                   i2s_ws_i,
	input  wire                   i2s_sd_i,
	output logic                  dma_req_o,
	output logic                  rx_intr_o,
	output logic                  dma_intr_o,
	output logic                  dis_intr_o
);

	// --------------------------------------------------
	// Internal nets
	// --------------------------------------------------
	i2s_rx_pkg::sample_t              sample;
	logic                             sample_push;
	logic                             i2s_stopped;
	logic                             en;
	i2s_rx_pkg::sample_t              rd_data;
	logic [i2s_rx_pkg::LEVEL_W-1:0]   level;
	logic                             empty;
	logic                             full;
	logic                             fifo_pop;
	logic                             fifo_flush;
	logic                             dma_start;
	logic [i2s_rx_pkg::LEVEL_W-1:0]   dma_cnt;
	logic                             busy;
	logic                             dma_done;

	// Serial side
	i2s_rx_deser #(.STOP_TIMEOUT(STOP_TIMEOUT)) deser_inst (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i),
		.i2s_sck_i(i2s_sck_i), .i2s_ws_i(i2s_ws_i), .i2s_sd_i(i2s_sd_i),
		.en_i(en), .sample_o(sample), .sample_push_o(sample_push),
		.stopped_o(i2s_stopped)
	);

	// Sample buffer
	i2s_rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_inst (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i), .flush_i(fifo_flush),
		.push_i(sample_push), .wr_data_i(sample), .pop_i(fifo_pop),
		.rd_data_o(rd_data), .level_o(level), .empty_o(empty), .full_o(full)
	);

	// Bus registers
	i2s_rx_regs regs_inst (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i),
		.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
		.wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
		.wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
		.fifo_data_i(rd_data), .fifo_level_i(level),
		.fifo_empty_i(empty), .fifo_full_i(full),
		.fifo_pop_o(fifo_pop), .fifo_flush_o(fifo_flush),
		.dma_busy_i(busy), .dma_done_i(dma_done),
		.dma_start_o(dma_start), .dma_cnt_o(dma_cnt),
		.stopped_i(i2s_stopped), .en_o(en),
		.rx_intr_o(rx_intr_o), .dma_intr_o(dma_intr_o), .dis_intr_o(dis_intr_o)
	);

	// System DMA request
	i2s_rx_dma_ctrl dma_ctrl_inst (
		.wbs_clk_i(wbs_clk_i), .rst_i(rst_i),
		.start_i(dma_start), .cnt_i(dma_cnt), .pop_i(fifo_pop),
		.fifo_empty_i(empty), .dma_req_o(dma_req_o),
		.busy_o(busy), .done_o(dma_done)
	);

endmodule

`default_nettype wire

// ==== i2s_rx_dma_ctrl.sv ====
// DMA request FSM with pop counter and done pulse
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_dma_ctrl (
	input  wire                            wbs_clk_i,
	input  wire                            rst_i,
	input  wire                            start_i,
	input  wire [i2s_rx_pkg::LEVEL_W-1:0]  cnt_i,
	input  wire                            pop_i,
	input  wire                            fifo_empty_i,
	output logic                           dma_req_o,
	output logic                           busy_o,
	output logic                           done_o
);

	localparam int LW = i2s_rx_pkg::LEVEL_W;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DONE
	} state_t;

	state_t        state_q;
	state_t        start_state;
	logic [LW-1:0] pop_cnt_q;
	logic [LW-1:0] cnt_q;
	logic          pop_ok;

	// Zero count finishes straight away
	assign start_state = (cnt_i == '0) ? ST_DONE : ST_RUN;

	// Pops of an empty FIFO move no data
	assign pop_ok = pop_i & ~fifo_empty_i;

	// --------------------------------------------------
	// State machine
	// --------------------------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			state_q   <= ST_IDLE;
			pop_cnt_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					pop_cnt_q <= '0;
					if (start_i)
						state_q <= start_state;
				end
				ST_RUN: begin
					// Start while running is dropped
					if (pop_ok) begin
						pop_cnt_q <= pop_cnt_q + 1'b1;
						if (pop_cnt_q + 1'b1 == cnt_q)
							state_q <= ST_DONE;
					end
				end
				ST_DONE: begin
					pop_cnt_q <= '0;
					state_q   <= start_i ? start_state : ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Run length captured at start
	always_ff @(posedge wbs_clk_i) begin
		if (start_i && state_q != ST_RUN)
			cnt_q <= cnt_i;
	end

	// Outputs straight from state
	assign busy_o    = (state_q == ST_RUN);
	assign done_o    = (state_q == ST_DONE);
	// Back-pressure while the FIFO is dry
	assign dma_req_o = busy_o & ~fifo_empty_i;

endmodule

`default_nettype wire

// ==== i2s_rx_dma_sva.sv ====
// Bound assertions on Wishbone ack, DMA request and FIFO flags of the I2S receiver
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_dma_sva #(
	parameter int FIFO_DEPTH = 16
) (
	input wire wbs_clk_i,
	input wire rst_i,
	input wire wbs_cyc_i,
	input wire wbs_stb_i,
	input wire wbs_ack_o,
	input wire dma_req_o,
	input wire push_i,
	input wire pop_i,
	input wire flush_i,
	input wire fifo_empty_i,
	input wire fifo_full_i
);

	// Failed assertions, summed up by the testbench
	int err_cnt = 0;

	// --------------------------------------------------
	// Bus
	// --------------------------------------------------
	// Ack cycles seen in the current request
	int unsigned acks_q;

	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || !(wbs_cyc_i && wbs_stb_i))
			acks_q <= 0;
		else if (wbs_ack_o)
			acks_q <= acks_q + 1;
	end

	// Exactly one ack cycle per request
	ack_one_cycle: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
		$fell(wbs_cyc_i && wbs_stb_i) |-> (acks_q == 1))
		else begin
			err_cnt++;
			$error("request ended with %0d ack cycles", acks_q);
		end

	// Ack only inside a live request
	ack_in_request: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
		wbs_ack_o |-> (wbs_cyc_i && wbs_stb_i))
		else begin
			err_cnt++;
			$error("ack without cyc and stb");
		end

	// --------------------------------------------------
	// DMA and FIFO
	// --------------------------------------------------
	// Occupancy rebuilt from push, pop and flush
	int   occ_q;
	logic push_ok;
	logic pop_ok;

	assign push_ok = push_i && (occ_q < FIFO_DEPTH);
	assign pop_ok  = pop_i && (occ_q > 0);

	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || flush_i)
			occ_q <= 0;
		else
			occ_q <= occ_q + int'(push_ok) - int'(pop_ok);
	end

	req_not_empty: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
		(occ_q == 0) |-> !dma_req_o)
		else begin
			err_cnt++;
			$error("DMA request raised while FIFO empty");
		end

	// Flags follow occupancy, so never full and empty together
	flags_exclusive: assert property (@(posedge wbs_clk_i) disable iff (rst_i)
		(fifo_empty_i == (occ_q == 0)) && (fifo_full_i == (occ_q == FIFO_DEPTH)))
		else begin
			err_cnt++;
			$error("FIFO flags disagree with occupancy %0d", occ_q);
		end

endmodule

bind i2s_rx_dma i2s_rx_dma_sva #(.FIFO_DEPTH(FIFO_DEPTH)) sva_inst (
	.wbs_clk_i(wbs_clk_i), .rst_i(rst_i),
	.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_ack_o(wbs_ack_o),
	.dma_req_o(dma_req_o),
	.push_i(sample_push), .pop_i(fifo_pop), .flush_i(fifo_flush),
	.fifo_empty_i(empty), .fifo_full_i(full)
);

`default_nettype wire

// ==== i2s_rx_fifo.sv ====
// Synchronous sample FIFO with flush, level, empty and full flags
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  wire                                  wbs_clk_i,
	input  wire                                  rst_i,
	input  wire                                  flush_i,
	input  wire                                  push_i,
	input  i2s_rx_pkg::sample_t                  wr_data_i,
	input  wire                                  pop_i,
	output i2s_rx_pkg::sample_t                  rd_data_o,
	output logic [i2s_rx_pkg::LEVEL_W-1:0]       level_o,
	output logic                                 empty_o,
	output logic                                 full_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int LW    = i2s_rx_pkg::LEVEL_W;

	i2s_rx_pkg::sample_t mem [FIFO_DEPTH];
	i2s_rx_pkg::sample_t last_q;
	logic [PTR_W-1:0]    wr_ptr_q;
	logic [PTR_W-1:0]    rd_ptr_q;
	logic [LW-1:0]       level_q;
	logic                push_ok;
	logic                pop_ok;

	assign empty_o = (level_q == '0);
	assign full_o  = (level_q == LW'(FIFO_DEPTH));
	assign level_o = level_q;

	// Full drops the push, empty drops the pop
	assign push_ok = push_i & ~full_o;
	assign pop_ok  = pop_i & ~empty_o;

	// Head of queue shown ahead, last popped word once drained
	assign rd_data_o = empty_o ? last_q : mem[rd_ptr_q];

	// --------------------------------------------------
	// Pointers and level
	// --------------------------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end else begin
			if (push_ok)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop_ok)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			level_q <= level_q + LW'(push_ok) - LW'(pop_ok);
		end
	end

	// Storage
	always_ff @(posedge wbs_clk_i) begin
		if (push_ok && !flush_i)
			mem[wr_ptr_q] <= wr_data_i;
	end

	// Held for reads of an empty FIFO
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i)
			last_q <= '0;
		else if (pop_ok && !flush_i)
			last_q <= mem[rd_ptr_q];
	end

endmodule

`default_nettype wire

// ==== i2s_rx_pkg.sv ====
// Shared widths, bus types, register map and status bit positions for the I2S receiver
`default_nettype none

package i2s_rx_pkg;

	// --------------------------------------------------
	// Widths and types
	// --------------------------------------------------
	localparam int WB_DATA_W = 32;
	localparam int WB_ADDR_W = 4;
	localparam int SAMPLE_W  = 16;

	// FIFO level and DMA count share one width
	localparam int LEVEL_W   = 5;

	// Three interrupt sources
	localparam int INTR_W    = 3;

	typedef logic [SAMPLE_W-1:0]  sample_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;

	// --------------------------------------------------
	// Register map, word addresses
	// --------------------------------------------------
	localparam wb_addr_t EN_REG_ADR        = 4'd0;
	localparam wb_addr_t INTR_STS_REG_ADR  = 4'd1;
	localparam wb_addr_t INTR_EN_REG_ADR   = 4'd2;
	localparam wb_addr_t FIFO_STS_REG_ADR  = 4'd3;
	localparam wb_addr_t FIFO_DATA_REG_ADR = 4'd4;
	localparam wb_addr_t FIFO_RST_REG_ADR  = 4'd5;
	localparam wb_addr_t DMA_EN_REG_ADR    = 4'd6;
	localparam wb_addr_t DMA_CNT_REG_ADR   = 4'd8;

	// Marks a read of an unmapped word
	localparam wb_data_t DEF_REG_VALUE     = 32'hDADDEFAC;

	// Status and enable bit positions, same in both registers
	localparam int STS_RX_BIT  = 0;
	localparam int STS_DMA_BIT = 1;
	localparam int STS_DIS_BIT = 2;

	// FIFO status flags above the level field
	localparam int FIFO_EMPTY_BIT = 16;
	localparam int FIFO_FULL_BIT  = 17;

endpackage

`default_nettype wire

// ==== i2s_rx_regs.sv ====
// Wishbone register file with interrupt status and enables, FIFO read port and DMA start
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_regs (
	input  wire                               wbs_clk_i,
	input  wire                               rst_i,
	input  wire                               wbs_cyc_i,
	input  wire                               wbs_stb_i,
	input  wire                               wbs_we_i,
	input  i2s_rx_pkg::wb_addr_t              wbs_adr_i,
	input  i2s_rx_pkg::wb_data_t              wbs_dat_i,
	output i2s_rx_pkg::wb_data_t              wbs_dat_o,
	output logic                              wbs_ack_o,
	input  i2s_rx_pkg::sample_t               fifo_data_i,
	input  wire [i2s_rx_pkg::LEVEL_W-1:0]     fifo_level_i,
	input  wire                               fifo_empty_i,
	input  wire                               fifo_full_i,
	output logic                              fifo_pop_o,
	output logic                              fifo_flush_o,
	input  wire                               dma_busy_i,
	input  wire                               dma_done_i,
	output logic                              dma_start_o,
	output logic [i2s_rx_pkg::LEVEL_W-1:0]    dma_cnt_o,
	input  wire                               stopped_i,
	output logic                              en_o,
	output logic                              rx_intr_o,
	output logic                              dma_intr_o,
	output logic                              dis_intr_o
);

	localparam int LW = i2s_rx_pkg::LEVEL_W;

	logic                          req;
	logic                          wr_en;
	logic                          rd_ack;
	i2s_rx_pkg::wb_data_t          rd_mux;
	logic                          en_q;
	logic [i2s_rx_pkg::INTR_W-1:0] intr_en_q;
	logic [LW-1:0]                 dma_cnt_q;
	logic                          sts_done_q;
	logic                          sts_dis_q;
	logic                          stopped_d_q;
	logic                          data_avail;

	// --------------------------------------------------
	// Bus handshake
	// --------------------------------------------------
	// New request only while ack is low
	assign req    = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
	// Writes and pops land in the ack cycle
	assign wr_en  = wbs_ack_o & wbs_we_i;
	assign rd_ack = wbs_ack_o & ~wbs_we_i;

	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			wbs_ack_o <= 1'b0;
			wbs_dat_o <= '0;
		end else begin
			wbs_ack_o <= req;
			if (req)
				wbs_dat_o <= rd_mux;
		end
	end

	assign fifo_pop_o   = rd_ack & (wbs_adr_i == i2s_rx_pkg::FIFO_DATA_REG_ADR);
	assign fifo_flush_o = wr_en & (wbs_adr_i == i2s_rx_pkg::FIFO_RST_REG_ADR);
	assign dma_start_o  = wr_en & (wbs_adr_i == i2s_rx_pkg::DMA_EN_REG_ADR) & wbs_dat_i[0];

	// --------------------------------------------------
	// Control registers
	// --------------------------------------------------
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			en_q      <= 1'b0;
			intr_en_q <= '0;
			dma_cnt_q <= '0;
		end else if (wr_en) begin
			case (wbs_adr_i)
				i2s_rx_pkg::EN_REG_ADR:      en_q      <= wbs_dat_i[0];
				i2s_rx_pkg::INTR_EN_REG_ADR: intr_en_q <= wbs_dat_i[i2s_rx_pkg::INTR_W-1:0];
				i2s_rx_pkg::DMA_CNT_REG_ADR: dma_cnt_q <= wbs_dat_i[LW-1:0];
				default: ;
			endcase
		end
	end

	assign en_o      = en_q;
	assign dma_cnt_o = dma_cnt_q;

	// Sticky status, a new event beats a W1C in the same cycle
	always_ff @(posedge wbs_clk_i) begin
		if (rst_i) begin
			sts_done_q  <= 1'b0;
			sts_dis_q   <= 1'b0;
			stopped_d_q <= 1'b0;
		end else begin
			stopped_d_q <= stopped_i;
			if (dma_done_i)
				sts_done_q <= 1'b1;
			else if (wr_en && wbs_adr_i == i2s_rx_pkg::INTR_STS_REG_ADR &&
					wbs_dat_i[i2s_rx_pkg::STS_DMA_BIT])
				sts_done_q <= 1'b0;
			if (stopped_i && !stopped_d_q)
				sts_dis_q <= 1'b1;
			else if (wr_en && wbs_adr_i == i2s_rx_pkg::INTR_STS_REG_ADR &&
					wbs_dat_i[i2s_rx_pkg::STS_DIS_BIT])
				sts_dis_q <= 1'b0;
		end
	end

	// Data available is a live level
	assign data_avail = ~fifo_empty_i;

	assign rx_intr_o  = data_avail & intr_en_q[i2s_rx_pkg::STS_RX_BIT];
	assign dma_intr_o = sts_done_q & intr_en_q[i2s_rx_pkg::STS_DMA_BIT];
	assign dis_intr_o = sts_dis_q & intr_en_q[i2s_rx_pkg::STS_DIS_BIT];

	// --------------------------------------------------
	// Read mux
	// --------------------------------------------------
	always_comb begin
		rd_mux = '0;
		case (wbs_adr_i)
			i2s_rx_pkg::EN_REG_ADR: rd_mux[0] = en_q;
			i2s_rx_pkg::INTR_STS_REG_ADR: begin
				rd_mux[i2s_rx_pkg::STS_RX_BIT]  = data_avail;
				rd_mux[i2s_rx_pkg::STS_DMA_BIT] = sts_done_q;
				rd_mux[i2s_rx_pkg::STS_DIS_BIT] = sts_dis_q;
			end
			i2s_rx_pkg::INTR_EN_REG_ADR: rd_mux[i2s_rx_pkg::INTR_W-1:0] = intr_en_q;
			i2s_rx_pkg::FIFO_STS_REG_ADR: begin
				rd_mux[LW-1:0]                    = fifo_level_i;
				rd_mux[i2s_rx_pkg::FIFO_EMPTY_BIT] = fifo_empty_i;
				rd_mux[i2s_rx_pkg::FIFO_FULL_BIT]  = fifo_full_i;
			end
			i2s_rx_pkg::FIFO_DATA_REG_ADR: rd_mux[i2s_rx_pkg::SAMPLE_W-1:0] = fifo_data_i;
			// Flush register is write only
			i2s_rx_pkg::FIFO_RST_REG_ADR: rd_mux = '0;
			i2s_rx_pkg::DMA_EN_REG_ADR:   rd_mux[0] = dma_busy_i;
			i2s_rx_pkg::DMA_CNT_REG_ADR:  rd_mux[LW-1:0] = dma_cnt_q;
			default: rd_mux = i2s_rx_pkg::DEF_REG_VALUE;
		endcase
	end

endmodule

`default_nettype wire

// ==== tb_i2s_rx_dma.sv ====
// Testbench for the I2S receiver: I2S master, Wishbone tasks, reference model, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_i2s_rx_dma;

	localparam int DEPTH     = 16;
	localparam int FRAME_CYC = 512;
	// About 35 frames of I2S traffic plus bus and idle time
	localparam int STIM_CYC  = 35 * FRAME_CYC + 4000;
	localparam int WDOG_CYC  = STIM_CYC * 12 / 10;

	logic                 clk;
	logic                 rst;
	logic                 wbs_cyc;
	logic                 wbs_stb;
	logic                 wbs_we;
	i2s_rx_pkg::wb_addr_t wbs_adr;
	i2s_rx_pkg::wb_data_t wbs_dat_w;
	i2s_rx_pkg::wb_data_t wbs_dat_r;
	logic                 wbs_ack;
	logic                 i2s_sck;
	logic                 i2s_ws;
	logic                 i2s_sd;
	logic                 dma_req;
	logic                 rx_intr;
	logic                 dma_intr;
	logic                 dis_intr;

	int                   mismatch_cnt;
	int                   fail_cnt;
	int unsigned          lcg_state;
	logic                 en_model;
	i2s_rx_pkg::sample_t  exp_q[$];

	i2s_rx_dma #(.FIFO_DEPTH(DEPTH), .STOP_TIMEOUT(64)) i2s_rx_dma_inst (
		.wbs_clk_i(clk), .rst_i(rst),
		.wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb), .wbs_we_i(wbs_we),
		.wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w),
		.wbs_dat_o(wbs_dat_r), .wbs_ack_o(wbs_ack),
		.i2s_sck_i(i2s_sck), .i2s_ws_i(i2s_ws), .i2s_sd_i(i2s_sd),
		.dma_req_o(dma_req), .rx_intr_o(rx_intr),
		.dma_intr_o(dma_intr), .dis_intr_o(dis_intr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// Reference model and random source
	// --------------------------------------------------
	function automatic i2s_rx_pkg::sample_t next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// Expected FIFO_STS word for a given fill level
	function automatic i2s_rx_pkg::wb_data_t fifo_sts_model(input int lvl);
		i2s_rx_pkg::wb_data_t w;
		w = i2s_rx_pkg::wb_data_t'(lvl);
		w[i2s_rx_pkg::FIFO_EMPTY_BIT] = (lvl == 0);
		w[i2s_rx_pkg::FIFO_FULL_BIT]  = (lvl == DEPTH);
		return w;
	endfunction

	// Sample is kept only when enabled and there is room
	function automatic bit fifo_accepts(input bit en, input int lvl);
		return en && (lvl < DEPTH);
	endfunction

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_word(input string name, input i2s_rx_pkg::wb_data_t got,
			input i2s_rx_pkg::wb_data_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_sample(input string name, input i2s_rx_pkg::sample_t got,
			input i2s_rx_pkg::sample_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// --------------------------------------------------
	// Wishbone master
	// --------------------------------------------------
	task automatic bus_cycle(input logic we, input i2s_rx_pkg::wb_addr_t adr,
			input i2s_rx_pkg::wb_data_t wdat, output i2s_rx_pkg::wb_data_t rdat);
		int waited;
		waited = 0;
		wbs_cyc   <= 1'b1;
		wbs_stb   <= 1'b1;
		wbs_we    <= we;
		wbs_adr   <= adr;
		wbs_dat_w <= wdat;
		do begin
			@(posedge clk);
			waited++;
		end while (!wbs_ack && waited < 50);
		if (!wbs_ack) begin
			fail_cnt++;
			$display("Bus cycle to address %0d got no ack", adr);
		end
		rdat = wbs_dat_r;
		wbs_cyc <= 1'b0;
		wbs_stb <= 1'b0;
		wbs_we  <= 1'b0;
		@(posedge clk);
	endtask

	task automatic reg_write(input i2s_rx_pkg::wb_addr_t adr, input i2s_rx_pkg::wb_data_t d);
		i2s_rx_pkg::wb_data_t unused;
		if (adr == i2s_rx_pkg::EN_REG_ADR)
			en_model = d[0];
		if (adr == i2s_rx_pkg::FIFO_RST_REG_ADR)
			exp_q.delete();
		bus_cycle(1'b1, adr, d, unused);
	endtask

	task automatic reg_read(input i2s_rx_pkg::wb_addr_t adr, output i2s_rx_pkg::wb_data_t d);
		bus_cycle(1'b0, adr, '0, d);
	endtask

	task automatic expect_reg(input string name, input i2s_rx_pkg::wb_addr_t adr,
			input i2s_rx_pkg::wb_data_t exp);
		i2s_rx_pkg::wb_data_t d;
		reg_read(adr, d);
		check_word(name, d, exp);
	endtask

	// Pop n samples and compare each with the model queue
	task automatic drain_and_check(input int n);
		i2s_rx_pkg::wb_data_t d;
		for (int i = 0; i < n; i++) begin
			reg_read(i2s_rx_pkg::FIFO_DATA_REG_ADR, d);
			if (exp_q.size() == 0) begin
				fail_cnt++;
				$display("FIFO read with no sample left in the model");
			end else begin
				check_sample("fifo_data", d[15:0], exp_q.pop_front());
			end
		end
	endtask

	// --------------------------------------------------
	// I2S master, one bit every 8 clocks
	// --------------------------------------------------
	task automatic send_bit(input logic w, input logic d);
		i2s_sck <= 1'b0;
		i2s_ws  <= w;
		i2s_sd  <= d;
		repeat (4) @(posedge clk);
		i2s_sck <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	// Leading right slot makes the first left word visible
	task automatic run_frames(input int n);
		i2s_rx_pkg::sample_t left;
		i2s_rx_pkg::sample_t right;
		send_bit(1'b1, 1'b0);
		for (int f = 0; f < n; f++) begin
			left  = next_rand();
			right = next_rand();
			if (fifo_accepts(en_model, exp_q.size()))
				exp_q.push_back(left);
			for (int s = 0; s < 32; s++)
				send_bit(1'b0, (s >= 1 && s <= 16) ? left[16 - s] : 1'b0);
			for (int s = 0; s < 32; s++)
				send_bit(1'b1, (s >= 1 && s <= 16) ? right[16 - s] : 1'b0);
		end
		// Let the last push settle
		repeat (10) @(posedge clk);
	endtask

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	initial begin
		repeat (WDOG_CYC) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WDOG_CYC);
		$display("*** FAILED ***");
		$finish;
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		i2s_rx_pkg::wb_data_t d;
		int                   assert_cnt;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		lcg_state    = 17240;
		en_model     = 1'b0;
		rst       = 1'b1;
		wbs_cyc   = 1'b0;
		wbs_stb   = 1'b0;
		wbs_we    = 1'b0;
		wbs_adr   = '0;
		wbs_dat_w = '0;
		i2s_sck   = 1'b1;
		i2s_ws    = 1'b1;
		i2s_sd    = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// Reset values and unmapped reads
		expect_reg("en", i2s_rx_pkg::EN_REG_ADR, '0);
		expect_reg("intr_sts", i2s_rx_pkg::INTR_STS_REG_ADR, '0);
		expect_reg("intr_en", i2s_rx_pkg::INTR_EN_REG_ADR, '0);
		expect_reg("fifo_sts", i2s_rx_pkg::FIFO_STS_REG_ADR, fifo_sts_model(0));
		expect_reg("fifo_data", i2s_rx_pkg::FIFO_DATA_REG_ADR, '0);
		expect_reg("fifo_rst", i2s_rx_pkg::FIFO_RST_REG_ADR, '0);
		expect_reg("dma_en", i2s_rx_pkg::DMA_EN_REG_ADR, '0);
		expect_reg("dma_cnt", i2s_rx_pkg::DMA_CNT_REG_ADR, '0);
		expect_reg("undef_7", 4'd7, i2s_rx_pkg::DEF_REG_VALUE);
		for (int a = 9; a < 16; a++)
			expect_reg("undef", i2s_rx_pkg::wb_addr_t'(a), i2s_rx_pkg::DEF_REG_VALUE);
		check_flag("dma_req_o", dma_req, 1'b0);

		// Left samples in order
		reg_write(i2s_rx_pkg::EN_REG_ADR, 32'd1);
		run_frames(4);
		expect_reg("fifo_sts", i2s_rx_pkg::FIFO_STS_REG_ADR, fifo_sts_model(exp_q.size()));
		drain_and_check(4);
		expect_reg("fifo_sts", i2s_rx_pkg::FIFO_STS_REG_ADR, fifo_sts_model(0));

		// Fill to full, overflow dropped
		run_frames(20);
		expect_reg("fifo_sts", i2s_rx_pkg::FIFO_STS_REG_ADR, fifo_sts_model(exp_q.size()));
		drain_and_check(DEPTH);
		run_frames(3);
		reg_write(i2s_rx_pkg::FIFO_RST_REG_ADR, 32'd1);
		expect_reg("fifo_sts", i2s_rx_pkg::FIFO_STS_REG_ADR, fifo_sts_model(0));

		// DMA run of three samples
		reg_write(i2s_rx_pkg::DMA_CNT_REG_ADR, 32'd3);
		reg_write(i2s_rx_pkg::INTR_EN_REG_ADR, 32'h2);
		run_frames(4);
		reg_write(i2s_rx_pkg::DMA_EN_REG_ADR, 32'd1);
		@(posedge clk);
		check_flag("dma_req_o", dma_req, 1'b1);
		expect_reg("dma_en", i2s_rx_pkg::DMA_EN_REG_ADR, 32'd1);
		drain_and_check(2);
		// One read short of the count keeps the run going
		expect_reg("dma_en", i2s_rx_pkg::DMA_EN_REG_ADR, 32'd1);
		check_flag("dma_req_o", dma_req, 1'b1);
		drain_and_check(1);
		repeat (3) @(posedge clk);
		check_flag("dma_req_o", dma_req, 1'b0);
		expect_reg("dma_en", i2s_rx_pkg::DMA_EN_REG_ADR, 32'd0);
		check_flag("dma_intr_o", dma_intr, 1'b1);
		reg_read(i2s_rx_pkg::INTR_STS_REG_ADR, d);
		check_flag("intr_sts.dma", d[i2s_rx_pkg::STS_DMA_BIT], 1'b1);
		reg_write(i2s_rx_pkg::INTR_STS_REG_ADR, 32'h2);
		@(posedge clk);
		check_flag("dma_intr_o", dma_intr, 1'b0);
		drain_and_check(1);

		// Stopped serial clock
		reg_write(i2s_rx_pkg::INTR_EN_REG_ADR, 32'h0);
		repeat (100) @(posedge clk);
		reg_read(i2s_rx_pkg::INTR_STS_REG_ADR, d);
		check_flag("intr_sts.dis", d[i2s_rx_pkg::STS_DIS_BIT], 1'b1);
		check_flag("dis_intr_o", dis_intr, 1'b0);
		reg_write(i2s_rx_pkg::INTR_EN_REG_ADR, 32'h4);
		@(posedge clk);
		check_flag("dis_intr_o", dis_intr, 1'b1);
		fork
			run_frames(1);
			begin
				// Clear while the clock runs again
				repeat (50) @(posedge clk);
				reg_write(i2s_rx_pkg::INTR_STS_REG_ADR, 32'h4);
				reg_read(i2s_rx_pkg::INTR_STS_REG_ADR, d);
				check_flag("intr_sts.dis", d[i2s_rx_pkg::STS_DIS_BIT], 1'b0);
				check_flag("dis_intr_o", dis_intr, 1'b0);
			end
		join
		drain_and_check(1);

		// Data available interrupt follows its enable
		reg_write(i2s_rx_pkg::INTR_EN_REG_ADR, 32'h0);
		run_frames(2);
		check_flag("rx_intr_o", rx_intr, 1'b0);
		reg_write(i2s_rx_pkg::INTR_EN_REG_ADR, 32'h1);
		@(posedge clk);
		check_flag("rx_intr_o", rx_intr, 1'b1);
		drain_and_check(2);
		repeat (2) @(posedge clk);
		check_flag("rx_intr_o", rx_intr, 1'b0);

		assert_cnt = i2s_rx_dma_inst.sva_inst.err_cnt;
		$display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_cnt, fail_cnt, assert_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0 && assert_cnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
